// ==== flist.f ====
daq_pkg.sv
src_ctrl_if.sv
bus_regs.sv
count_source.sv
word_merger.sv
daq_core.sv
tb_clk_gen.sv
tb_daq_core.sv

// ==== tb_daq_core.sv ====
module tb_daq_core;

    localparam int n_tests      = 5;
    localparam int clk_per      = 10;
    localparam int quiet_cycles = 40;

    logic                        clk;
    logic                        rst_n;
    logic [31:0]                 bus_add;
    logic                        bus_rd;
    logic                        bus_wr;
    logic                        bus_drive;
    logic [31:0]                 bus_wdata;
    wire  [31:0]                 bus_data;
    logic                        fifo_next;
    logic                        fifo_full;
    logic                        fifo_write;
    logic [31:0]                 fifo_data;
    logic [7:0]                  led;

    string                       t_name   [n_tests];
    logic [daq_pkg::n_src-1:0]   t_mask   [n_tests];
    int                          t_period [n_tests][daq_pkg::n_src];
    int                          t_words  [n_tests];
    bit                          t_bp     [n_tests];
    bit                          t_clear  [n_tests];
    logic [7:0]                  t_led    [n_tests];

    string                       cur_name;
    logic [daq_pkg::n_src-1:0]   cur_mask;
    bit                          bp_on;
    bit                          stalled;
    int                          stretch;
    int                          exp_seq  [daq_pkg::n_src];
    int                          sent_exp [daq_pkg::n_src];
    int                          got      [daq_pkg::n_src];
    int                          err_cnt;
    int                          fail_tests;
    longint                      limit;
    bit                          limit_ready;
    int unsigned                 seed;

    tb_clk_gen #(.period(clk_per)) u_clk (.clk(clk), .rst_n(rst_n));

    assign bus_data = bus_drive ? bus_wdata : 32'bz;

    daq_core u_dut (
        .BUS_CLK    (clk),
        .rst_n      (rst_n),
        .BUS_ADD    (bus_add),
        .BUS_DATA   (bus_data),
        .BUS_RD     (bus_rd),
        .BUS_WR     (bus_wr),
        .fifo_full  (fifo_full),
        .FIFO_NEXT  (fifo_next),
        .FIFO_WRITE (fifo_write),
        .FIFO_DATA  (fifo_data),
        .LED        (led)
    );

    task automatic set_row(input int t, input string name,
                           input logic [daq_pkg::n_src-1:0] mask,
                           input int p0, input int p1, input int p2, input int p3,
                           input int words, input bit bp, input bit clr,
                           input logic [7:0] led_val);
        t_name[t]      = name;
        t_mask[t]      = mask;
        t_period[t][0] = p0;
        t_period[t][1] = p1;
        t_period[t][2] = p2;
        t_period[t][3] = p3;
        t_words[t]     = words;
        t_bp[t]        = bp;
        t_clear[t]     = clr;
        t_led[t]       = led_val;
    endtask

    // name, mask, periods ch0 to ch3, words, back-pressure, clear, LED.
    task automatic fill_table();
        set_row(0, "single_ch0",    4'b0001, 3, 0, 0, 0, 12, 1'b0, 1'b1, 8'hA5);
        set_row(1, "single_ch2",    4'b0100, 0, 0, 5, 0, 10, 1'b0, 1'b1, 8'h3C);
        // no clear, so ch0 and ch2 carry on from their last values.
        set_row(2, "all_sources",   4'b1111, 0, 2, 5, 9, 16, 1'b0, 1'b0, 8'h0F);
        set_row(3, "backpressure",  4'b1111, 1, 0, 3, 2, 20, 1'b1, 1'b0, 8'hF0);
        set_row(4, "clear_restart", 4'b1010, 4, 1, 0, 6,  8, 1'b1, 1'b1, 8'h81);
    endtask

    // words x (slowest period + 20) cycles per test, plus bus and drain time.
    function automatic longint run_limit();
        longint total;
        int     n_on;
        int     maxp;
        total = 0;
        for (int t = 0; t < n_tests; t++) begin
            n_on = 0;
            maxp = 0;
            for (int ch = 0; ch < daq_pkg::n_src; ch++) begin
                if (t_mask[t][ch]) begin
                    n_on++;
                    if (t_period[t][ch] > maxp) maxp = t_period[t][ch];
                end
            end
            total += longint'(t_words[t] * n_on) * (maxp + 20 + (t_bp[t] ? 16 : 0)) * clk_per;
            total += 400 * clk_per;
        end
        return total + 2000;
    endfunction

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("MISMATCH %s %s: expected %0d, actual %0d", cur_name, what, expected, actual);
        err_cnt++;
    endtask

    task automatic report_fault(input string msg);
        $display("ERROR %s: %s", cur_name, msg);
        err_cnt++;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
        @(negedge clk);
        bus_add   = addr;
        bus_wdata = wdata;
        bus_drive = 1'b1;
        bus_wr    = 1'b1;
        @(negedge clk);
        bus_wr    = 1'b0;
        bus_drive = 1'b0;
        bus_add   = '0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
        @(negedge clk);
        bus_add = addr;
        bus_rd  = 1'b1;
        @(posedge clk);
        rdata   = bus_data;
        @(negedge clk);
        bus_rd  = 1'b0;
        bus_add = '0;
    endtask

    function automatic bit words_done(input int words);
        for (int ch = 0; ch < daq_pkg::n_src; ch++) begin
            if (cur_mask[ch] && got[ch] < words) return 1'b0;
        end
        return 1'b1;
    endfunction

    // FIFO model, alternating random run and stall stretches.
    initial begin : fifo_model
        seed = $urandom(30059);  // seeds the stall pattern.
        forever begin
            @(negedge clk);
            if (!bp_on) begin
                fifo_next = 1'b1;
                fifo_full = 1'b0;
                stretch   = 0;
            end else if (stretch > 0) begin
                stretch--;
            end else begin
                stalled = !stalled;
                stretch = $urandom % 10;
                if (stalled) begin
                    case ($urandom % 3)
                        0: begin
                            fifo_next = 1'b0;
                            fifo_full = 1'b0;
                        end
                        1: begin
                            fifo_next = 1'b1;
                            fifo_full = 1'b1;
                        end
                        default: begin
                            fifo_next = 1'b0;
                            fifo_full = 1'b1;
                        end
                    endcase
                end else begin
                    fifo_next = 1'b1;
                    fifo_full = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin : scoreboard
        int ch;
        int sq;
        if (rst_n && fifo_write) begin
            ch = int'(fifo_data[31:28]);
            sq = int'(fifo_data[27:0]);
            if (!fifo_next || fifo_full) report_fault("FIFO_WRITE high during a FIFO stall");
            if (ch >= daq_pkg::n_src) begin
                report_fault("word carries a channel tag with no source behind it");
            end else begin
                if (!cur_mask[ch]) report_fault("word arrived from a disabled channel");
                if (sq != exp_seq[ch]) begin
                    report_mismatch($sformatf("ch%0d seq", ch), exp_seq[ch], sq);
                end
                exp_seq[ch]++;
                got[ch]++;
                sent_exp[ch]++;
            end
        end
    end

    task automatic run_test(input int t);
        logic [31:0] rdata;
        int          errs_before;
        int          quiet;
        cur_name    = t_name[t];
        errs_before = err_cnt;
        for (int ch = 0; ch < daq_pkg::n_src; ch++) got[ch] = 0;
        if (t_clear[t]) begin
            bus_write(daq_pkg::base_addr + daq_pkg::reg_clear, 32'hF);
            repeat (2) @(negedge clk);
            for (int ch = 0; ch < daq_pkg::n_src; ch++) begin
                exp_seq[ch]  = 0;
                sent_exp[ch] = 0;
                bus_read(daq_pkg::base_addr + daq_pkg::reg_sent0 + 32'(4 * ch), rdata);
                if (rdata != 0) report_mismatch($sformatf("ch%0d sent after clear", ch), 0, rdata);
            end
        end
        for (int ch = 0; ch < daq_pkg::n_src; ch++) begin
            bus_write(daq_pkg::base_addr + daq_pkg::reg_period0 + 32'(4 * ch), t_period[t][ch]);
        end
        bus_write(daq_pkg::base_addr + daq_pkg::reg_led, 32'(t_led[t]));
        for (int ch = 0; ch < daq_pkg::n_src; ch++) begin
            bus_read(daq_pkg::base_addr + daq_pkg::reg_period0 + 32'(4 * ch), rdata);
            if (rdata != t_period[t][ch]) begin
                report_mismatch($sformatf("ch%0d period", ch), t_period[t][ch], rdata);
            end
        end
        bus_read(daq_pkg::base_addr + daq_pkg::reg_led, rdata);
        if (rdata != t_led[t]) report_mismatch("LED register", t_led[t], rdata);
        if (led != t_led[t]) report_mismatch("LED port", t_led[t], led);

        cur_mask = t_mask[t];
        bp_on    = t_bp[t];
        bus_write(daq_pkg::base_addr + daq_pkg::reg_enable, 32'(t_mask[t]));
        while (!words_done(t_words[t])) @(negedge clk);

        // disable, then let in-flight handshakes and the slot drain.
        bus_write(daq_pkg::base_addr + daq_pkg::reg_enable, 32'h0);
        bp_on = 1'b0;
        quiet = 0;
        while (quiet < quiet_cycles) begin
            @(posedge clk);
            if (fifo_write) quiet = 0;
            else quiet++;
        end
        for (int ch = 0; ch < daq_pkg::n_src; ch++) begin
            bus_read(daq_pkg::base_addr + daq_pkg::reg_sent0 + 32'(4 * ch), rdata);
            if (rdata != sent_exp[ch]) begin
                report_mismatch($sformatf("ch%0d sent", ch), sent_exp[ch], rdata);
            end
        end
        cur_mask = '0;
        if (err_cnt != errs_before) fail_tests++;
        $display("test %-14s %s  words %0d/%0d/%0d/%0d", cur_name,
                 (err_cnt == errs_before) ? "ok" : "failed", got[0], got[1], got[2], got[3]);
    endtask

    initial begin
        bus_add    = '0;
        bus_rd     = 1'b0;
        bus_wr     = 1'b0;
        bus_drive  = 1'b0;
        bus_wdata  = '0;
        fifo_next  = 1'b0;
        fifo_full  = 1'b0;
        bp_on      = 1'b0;
        stalled    = 1'b0;
        stretch    = 0;
        cur_mask   = '0;
        cur_name   = "reset";
        err_cnt    = 0;
        fail_tests = 0;
        for (int ch = 0; ch < daq_pkg::n_src; ch++) begin
            exp_seq[ch]  = 0;
            sent_exp[ch] = 0;
            got[ch]      = 0;
        end
        fill_table();
        limit       = run_limit();
        limit_ready = 1'b1;
        wait (rst_n === 1'b1);
        @(negedge clk);
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_tests, n_tests - fail_tests, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog.
    initial begin
        wait (limit_ready);
        #(limit);
        $display("timeout: run still going after %0d time units, FIFO words stopped coming", limit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int period     = 10,
    parameter int rst_cycles = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        #(period * rst_cycles) rst_n = 1'b1;  // released on a falling edge.
    end

endmodule

// ==== daq_core.sv ====
module daq_core (
    input  logic         BUS_CLK,
    input  logic         rst_n,
    input  logic [31:0]  BUS_ADD,
    inout  wire  [31:0]  BUS_DATA,
    input  logic         BUS_RD,
    input  logic         BUS_WR,
    input  logic         fifo_full,
    input  logic         FIFO_NEXT,
    output logic         FIFO_WRITE,
    output logic [31:0]  FIFO_DATA,
    output logic [7:0]   LED
);

    // per-source word channels.
    logic [daq_pkg::n_src-1:0]   src_req;
    logic [daq_pkg::n_src-1:0]   src_ack;
    logic [daq_pkg::data_w-1:0]  src_data [daq_pkg::n_src];

    src_ctrl_if ctrl [daq_pkg::n_src] ();

    bus_regs u_regs (
        .BUS_CLK  (BUS_CLK),
        .rst_n    (rst_n),
        .BUS_ADD  (BUS_ADD),
        .BUS_DATA (BUS_DATA),
        .BUS_RD   (BUS_RD),
        .BUS_WR   (BUS_WR),
        .led      (LED),
        .ctrl     (ctrl)
    );

    for (genvar i = 0; i < daq_pkg::n_src; i++) begin : g_src
        count_source #(
            .channel (i)  // tag lands in bits 31:28.
        ) u_src (
            .BUS_CLK (BUS_CLK),
            .rst_n   (rst_n),
            .ack     (src_ack[i]),
            .req     (src_req[i]),
            .data    (src_data[i]),
            .ctrl    (ctrl[i])
        );
    end

    word_merger u_merge (
        .BUS_CLK    (BUS_CLK),
        .rst_n      (rst_n),
        .req        (src_req),
        .data       (src_data),
        .FIFO_NEXT  (FIFO_NEXT),
        .fifo_full  (fifo_full),
        .ack        (src_ack),
        .FIFO_WRITE (FIFO_WRITE),
        .FIFO_DATA  (FIFO_DATA)
    );

endmodule

// ==== word_merger.sv ====
module word_merger (
    input  logic                        BUS_CLK,
    input  logic                        rst_n,
    input  logic [daq_pkg::n_src-1:0]   req,
    input  logic [daq_pkg::data_w-1:0]  data [daq_pkg::n_src],
    input  logic                        FIFO_NEXT,
    input  logic                        fifo_full,
    output logic [daq_pkg::n_src-1:0]   ack,
    output logic                        FIFO_WRITE,
    output logic [31:0]                 FIFO_DATA
);

    daq_pkg::merge_state_t            state;
    logic [daq_pkg::src_idx_w-1:0]    ptr;         // first source to look at.
    logic [daq_pkg::src_idx_w-1:0]    sel;         // source being served.
    logic [daq_pkg::n_src-1:0]        ack_r;
    logic                             slot_full;
    logic [daq_pkg::data_w-1:0]       slot_data;

    logic [daq_pkg::src_idx_w-1:0]    grant;
    logic [daq_pkg::src_idx_w-1:0]    cand;
    logic                             grant_valid;
    logic                             fifo_take;

    // round robin, nearest requester at or after ptr wins.
    always_comb begin
        grant_valid = 1'b0;
        grant       = ptr;
        cand        = ptr;
        for (int k = daq_pkg::n_src - 1; k >= 0; k--) begin
            cand = ptr + daq_pkg::src_idx_w'(k);
            if (req[cand]) begin
                grant_valid = 1'b1;
                grant       = cand;
            end
        end
    end

    assign fifo_take = slot_full && FIFO_NEXT && !fifo_full;

    always_ff @(posedge BUS_CLK or negedge rst_n) begin
        if (!rst_n) begin
            state     <= daq_pkg::idle;
            ptr       <= '0;
            sel       <= '0;
            ack_r     <= '0;
            slot_full <= 1'b0;
        end else begin
            if (fifo_take) begin
                slot_full <= 1'b0;  // word handed to the FIFO.
            end
            case (state)
                daq_pkg::idle: begin
                    if (grant_valid && !slot_full) begin
                        sel          <= grant;
                        ptr          <= grant + 1'b1;
                        ack_r[grant] <= 1'b1;
                        state        <= daq_pkg::ack_high;
                    end
                end
                daq_pkg::ack_high: begin
                    slot_full <= 1'b1;  // data still held by the source.
                    state     <= daq_pkg::wait_req_low;
                end
                daq_pkg::wait_req_low: begin
                    if (!req[sel]) begin
                        ack_r[sel] <= 1'b0;
                        state      <= daq_pkg::idle;
                    end
                end
                default: state <= daq_pkg::idle;
            endcase
        end
    end

    // payload register, captured while the source still holds req.
    always_ff @(posedge BUS_CLK) begin
        if (state == daq_pkg::ack_high) begin
            slot_data <= data[sel];
        end
    end

    assign ack        = ack_r;
    assign FIFO_WRITE = fifo_take;
    assign FIFO_DATA  = slot_data;

    for (genvar g = 0; g < daq_pkg::n_src; g++) begin : g_chk
        // only a requesting source gets acked.
        a_ack_on_req: assert property (
            @(posedge BUS_CLK) disable iff (!rst_n)
            $rose(ack[g]) |-> req[g]
        );
    end

    a_no_write_full: assert property (
        @(posedge BUS_CLK) disable iff (!rst_n)
        FIFO_WRITE |-> !fifo_full
    );

endmodule

// ==== count_source.sv ====
module count_source #(
    parameter int channel = 0
) (
    input  logic                       BUS_CLK,
    input  logic                       rst_n,
    input  logic                       ack,
    output logic                       req,
    output logic [daq_pkg::data_w-1:0] data,
    src_ctrl_if.source                 ctrl
);

    typedef enum logic [1:0] {
        pace,          // counting down the gap to the next word.
        req_high,      // word offered, waiting for ack.
        wait_ack_low   // req dropped, waiting for ack to fall.
    } src_state_t;

    src_state_t                    state;
    logic [daq_pkg::period_w-1:0]  pace_cnt;
    logic [daq_pkg::seq_w-1:0]     seq_r;
    logic [daq_pkg::seq_w-1:0]     sent_r;

    always_ff @(posedge BUS_CLK or negedge rst_n) begin
        if (!rst_n) begin
            state    <= pace;
            pace_cnt <= '0;
            seq_r    <= '0;
            sent_r   <= '0;
        end else begin
            case (state)
                pace: begin
                    // clear and enable only act between handshakes.
                    if (ctrl.clear) begin
                        seq_r    <= '0;
                        sent_r   <= '0;
                        pace_cnt <= '0;
                    end else if (!ctrl.enable) begin
                        pace_cnt <= '0;
                    end else if (pace_cnt >= ctrl.period) begin
                        state <= req_high;  // word ready.
                    end else begin
                        pace_cnt <= pace_cnt + 1'b1;
                    end
                end
                req_high: begin
                    if (ack) begin
                        state <= wait_ack_low;
                    end
                end
                wait_ack_low: begin
                    if (!ack) begin
                        // handshake done, next word may change now.
                        seq_r    <= seq_r + 1'b1;
                        sent_r   <= sent_r + 1'b1;
                        pace_cnt <= '0;
                        state    <= pace;
                    end
                end
                default: state <= pace;
            endcase
        end
    end

    assign req             = (state == req_high);
    assign data            = {daq_pkg::chan_w'(channel), seq_r};
    assign ctrl.sent_count = sent_r;

    // an offered word is never withdrawn before the merger takes it.
    a_req_hold: assert property (
        @(posedge BUS_CLK) disable iff (!rst_n)
        (req && !ack) |=> req
    );

endmodule

// ==== bus_regs.sv ====
module bus_regs (
    input  logic                       BUS_CLK,
    input  logic                       rst_n,
    input  logic [31:0]                BUS_ADD,
    inout  wire  [31:0]                BUS_DATA,
    input  logic                       BUS_RD,
    input  logic                       BUS_WR,
    output logic [daq_pkg::led_w-1:0]  led,
    src_ctrl_if.regs                   ctrl [daq_pkg::n_src]
);

    logic [31:0]                     off;
    logic                            in_range;
    logic                            wr_hit;
    logic                            is_period;
    logic                            is_sent;
    logic [daq_pkg::src_idx_w-1:0]   idx;
    logic [31:0]                     rd_data;

    logic [daq_pkg::n_src-1:0]       enable_r;
    logic [daq_pkg::n_src-1:0]       clear_r;
    logic [daq_pkg::led_w-1:0]       led_r;
    logic [daq_pkg::period_w-1:0]    period_r [daq_pkg::n_src];
    logic [daq_pkg::seq_w-1:0]       sent_cnt [daq_pkg::n_src];

    assign in_range  = (BUS_ADD >= daq_pkg::base_addr) && (BUS_ADD <= daq_pkg::high_addr);
    assign off       = BUS_ADD - daq_pkg::base_addr;
    assign wr_hit    = BUS_WR && in_range;
    assign idx       = off[daq_pkg::src_idx_w+1:2];  // word index inside a block.

    assign is_period = (off >= daq_pkg::reg_period0) &&
                       (off < daq_pkg::reg_period0 + 32'(4 * daq_pkg::n_src));
    assign is_sent   = (off >= daq_pkg::reg_sent0) &&
                       (off < daq_pkg::reg_sent0 + 32'(4 * daq_pkg::n_src));

    always_ff @(posedge BUS_CLK or negedge rst_n) begin
        if (!rst_n) begin
            enable_r <= '0;
            clear_r  <= '0;
            led_r    <= '0;
            for (int i = 0; i < daq_pkg::n_src; i++) begin
                period_r[i] <= '0;
            end
        end else begin
            clear_r <= '0;  // strobes last one cycle.
            if (wr_hit) begin
                if (off == daq_pkg::reg_enable) begin
                    enable_r <= BUS_DATA[daq_pkg::n_src-1:0];
                end
                if (off == daq_pkg::reg_clear) begin
                    clear_r <= BUS_DATA[daq_pkg::n_src-1:0];
                end
                if (off == daq_pkg::reg_led) begin
                    led_r <= BUS_DATA[daq_pkg::led_w-1:0];
                end
                if (is_period) begin
                    period_r[idx] <= BUS_DATA[daq_pkg::period_w-1:0];
                end
            end
        end
    end

    always_comb begin
        rd_data = '0;
        if (is_period) begin
            rd_data = 32'(period_r[idx]);
        end else if (is_sent) begin
            rd_data = 32'(sent_cnt[idx]);
        end else begin
            case (off)
                daq_pkg::reg_enable: rd_data[daq_pkg::n_src-1:0] = enable_r;
                daq_pkg::reg_led:    rd_data[daq_pkg::led_w-1:0] = led_r;
                default:             rd_data = '0;  // clear reads as zero.
            endcase
        end
    end

    assign BUS_DATA = (BUS_RD && in_range) ? rd_data : 32'bz;
    assign led      = led_r;

    for (genvar g = 0; g < daq_pkg::n_src; g++) begin : g_ctrl
        assign ctrl[g].enable = enable_r[g];
        assign ctrl[g].clear  = clear_r[g];
        assign ctrl[g].period = period_r[g];
        assign sent_cnt[g]    = ctrl[g].sent_count;

        // a clear strobe never stretches past one cycle.
        a_clear_pulse: assert property (
            @(posedge BUS_CLK) disable iff (!rst_n)
            clear_r[g] |=> !clear_r[g]
        );
    end

endmodule

// ==== src_ctrl_if.sv ====
interface src_ctrl_if;

    logic                          enable;
    logic                          clear;       // one-cycle strobe.
    logic [daq_pkg::period_w-1:0]  period;
    logic [daq_pkg::seq_w-1:0]     sent_count;

    // register side drives the controls and reads back the count.
    modport regs (
        output enable,
        output clear,
        output period,
        input  sent_count
    );

    // source side follows the controls and reports its count.
    modport source (
        input  enable,
        input  clear,
        input  period,
        output sent_count
    );

endinterface

// ==== daq_pkg.sv ====
package daq_pkg;

    // source array shape.
    localparam int n_src      = 4;
    localparam int src_idx_w  = $clog2(n_src);

    // word layout, channel tag above the sequence number.
    localparam int chan_w     = 4;
    localparam int seq_w      = 28;
    localparam int data_w     = chan_w + seq_w;

    // pacing and LED widths.
    localparam int period_w   = 16;
    localparam int led_w      = 8;

    // register window on the bus.
    localparam logic [31:0] base_addr   = 32'h0000_1000;
    localparam logic [31:0] high_addr   = 32'h0000_102F;

    // offsets from base_addr.
    localparam logic [31:0] reg_enable  = 32'h00;  // bit n enables source n.
    localparam logic [31:0] reg_clear   = 32'h04;  // write-only clear strobes.
    localparam logic [31:0] reg_led     = 32'h08;
    localparam logic [31:0] reg_period0 = 32'h10;  // one word per source.
    localparam logic [31:0] reg_sent0   = 32'h20;  // read-only handshake counts.

    // merger handshake states.
    typedef enum logic [1:0] {
        idle,          // slot may take a new word.
        ack_high,      // ack raised, word captured this cycle.
        wait_req_low   // holding ack until the source drops req.
    } merge_state_t;

endpackage
